// ==== src/ic_msg_pkg.sv ====
package ic_msg_pkg;

  // ==============================
  // message field widths
  // ==============================

  localparam int ADDR_W = 4;
  localparam int DATA_W = 16;

  // destination address on the way in, source number on the way out
  typedef logic [ADDR_W-1:0] addr_t;

  // payload carried by every stream
  typedef logic [DATA_W-1:0] data_t;

  // ==============================
  // message layout
  // ==============================

  // addr sits above data, 20 bits in total
  typedef struct packed {
    addr_t addr;
    data_t data;
  } msg_t;

endpackage

// ==== src/ic_map_pkg.sv ====
package ic_map_pkg;

  // ==============================
  // address map
  // ==============================

  // decoded destination of an incoming message
  // values 4 to 15 are unmapped and get dropped by the router
  typedef enum logic [ic_msg_pkg::ADDR_W-1:0] {
    DEST_XBAR_IN0 = 4'd0,
    DEST_XBAR_IN1 = 4'd1,
    DEST_XBAR_CFG = 4'd2,
    DEST_LOOPBACK = 4'd3
  } dest_e;

  // ==============================
  // crossbar control word
  // ==============================

  // low two bits of a config payload
  typedef struct packed {
    logic out_sel;
    logic in_sel;
  } xbar_ctrl_t;

  // in0 to out0 after reset
  localparam xbar_ctrl_t XBAR_RESET_CTRL = '{out_sel: 1'b0, in_sel: 1'b0};

  // ==============================
  // arbiter source numbers
  // ==============================

  typedef logic [1:0] src_id_t;

  localparam src_id_t SRC_XBAR_OUT0 = 2'd0;
  localparam src_id_t SRC_XBAR_OUT1 = 2'd1;
  localparam src_id_t SRC_LOOPBACK  = 2'd2;

endpackage

// ==== src/msg_router.sv ====
module msg_router (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  ic_msg_pkg::msg_t       in_msg_i,
  input  logic                   in_val_i,
  output logic                   in_rdy_o,
  output ic_msg_pkg::data_t      xbar_data_o,
  output logic [1:0]             xbar_val_o,
  input  logic [1:0]             xbar_rdy_i,
  output ic_map_pkg::xbar_ctrl_t cfg_o,
  output logic                   cfg_val_o,
  output ic_msg_pkg::data_t      loop_data_o,
  output logic                   loop_val_o,
  input  logic                   loop_rdy_i
);

  ic_msg_pkg::msg_t  buf_q;
  logic              buf_val_q;
  ic_map_pkg::dest_e dest;
  logic              dest_rdy;
  logic              buf_free;
  logic              in_fire;

  // ==============================
  // address decode
  // ==============================

  assign dest = ic_map_pkg::dest_e'(buf_q.addr);

  // config and unmapped words never wait
  always_comb begin
    case (dest)
      ic_map_pkg::DEST_XBAR_IN0: dest_rdy = xbar_rdy_i[0];
      ic_map_pkg::DEST_XBAR_IN1: dest_rdy = xbar_rdy_i[1];
      ic_map_pkg::DEST_XBAR_CFG: dest_rdy = 1'b1;
      ic_map_pkg::DEST_LOOPBACK: dest_rdy = loop_rdy_i;
      default:                   dest_rdy = 1'b1;
    endcase
  end

  assign buf_free = buf_val_q & dest_rdy;
  assign in_rdy_o = ~buf_val_q | buf_free;
  assign in_fire  = in_val_i & in_rdy_o;

  // ==============================
  // destination streams
  // ==============================

  // only the matching destination sees valid
  assign xbar_val_o[0] = buf_val_q && (dest == ic_map_pkg::DEST_XBAR_IN0);
  assign xbar_val_o[1] = buf_val_q && (dest == ic_map_pkg::DEST_XBAR_IN1);
  assign cfg_val_o     = buf_val_q && (dest == ic_map_pkg::DEST_XBAR_CFG);
  assign loop_val_o    = buf_val_q && (dest == ic_map_pkg::DEST_LOOPBACK);

  assign xbar_data_o = buf_q.data;
  assign loop_data_o = buf_q.data;
  assign cfg_o       = ic_map_pkg::xbar_ctrl_t'(buf_q.data[$bits(ic_map_pkg::xbar_ctrl_t)-1:0]);

  // ==============================
  // one-entry buffer
  // ==============================

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      buf_val_q <= 1'b0;
    end else if (in_fire) begin
      buf_val_q <= 1'b1;
    end else if (buf_free) begin
      buf_val_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      buf_q <= in_msg_i;
    end
  end

endmodule

// ==== src/blocking_xbar.sv ====
module blocking_xbar (
  input  logic                        clk,
  input  logic                        rst_n_i,
  input  ic_msg_pkg::data_t           in_data_i,
  input  logic [1:0]                  in_val_i,
  output logic [1:0]                  in_rdy_o,
  input  ic_map_pkg::xbar_ctrl_t      cfg_i,
  input  logic                        cfg_val_i,
  output ic_msg_pkg::data_t [1:0]     out_data_o,
  output logic [1:0]                  out_val_o,
  input  logic [1:0]                  out_rdy_i
);

  ic_map_pkg::xbar_ctrl_t route_q;

  // ==============================
  // route register
  // ==============================

  // config is always taken, new route from next cycle
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      route_q <= ic_map_pkg::XBAR_RESET_CTRL;
    end else if (cfg_val_i) begin
      route_q <= cfg_i;
    end
  end

  // ==============================
  // switch fabric
  // ==============================

  // selected input to selected output, everything else blocked
  always_comb begin
    out_val_o  = '0;
    out_data_o = '0;
    out_val_o[route_q.out_sel]  = in_val_i[route_q.in_sel];
    out_data_o[route_q.out_sel] = in_data_i;
  end

  // the unselected input stalls
  always_comb begin
    in_rdy_o = '0;
    in_rdy_o[route_q.in_sel] = out_rdy_i[route_q.out_sel];
  end

endmodule

// ==== src/rr_arbiter.sv ====
module rr_arbiter #(
  parameter int N_SRC = 3
) (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  ic_msg_pkg::data_t [N_SRC-1:0] src_data_i,
  input  logic [N_SRC-1:0]              src_val_i,
  output logic [N_SRC-1:0]              src_rdy_o,
  output ic_msg_pkg::msg_t              out_msg_o,
  output logic                          out_val_o,
  input  logic                          out_rdy_i
);

  ic_map_pkg::src_id_t last_q;
  ic_map_pkg::src_id_t grant_idx;
  logic                grant_found;
  logic                grant_val;
  logic                can_take;
  ic_msg_pkg::msg_t    out_q;
  logic                out_val_q;

  // ==============================
  // grant selection
  // ==============================

  // search starts one past the last grant
  always_comb begin
    int idx;
    idx         = 0;
    grant_found = 1'b0;
    grant_idx   = '0;
    for (int off = 1; off <= N_SRC; off++) begin
      idx = int'(last_q) + off;
      if (idx >= N_SRC) begin
        idx = idx - N_SRC;
      end
      if (!grant_found && src_val_i[idx]) begin
        grant_found = 1'b1;
        grant_idx   = ic_map_pkg::src_id_t'(idx);
      end
    end
  end

  // output register free or draining this cycle
  assign can_take  = ~out_val_q | out_rdy_i;
  assign grant_val = can_take & grant_found;

  always_comb begin
    src_rdy_o = '0;
    src_rdy_o[grant_idx] = grant_val;
  end

  // ==============================
  // priority pointer
  // ==============================

  // moves only on a real grant
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      last_q <= ic_map_pkg::src_id_t'(N_SRC - 1);
    end else if (grant_val) begin
      last_q <= grant_idx;
    end
  end

  // ==============================
  // output register
  // ==============================

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      out_val_q <= 1'b0;
    end else if (grant_val) begin
      out_val_q <= 1'b1;
    end else if (out_rdy_i) begin
      out_val_q <= 1'b0;
    end
  end

  // source number goes into the addr field
  always_ff @(posedge clk) begin
    if (grant_val) begin
      out_q.addr <= ic_msg_pkg::addr_t'(grant_idx);
      out_q.data <= src_data_i[grant_idx];
    end
  end

  assign out_msg_o = out_q;
  assign out_val_o = out_val_q;

endmodule

// ==== src/msg_interconnect.sv ====
module msg_interconnect (
  input  logic             clk,
  input  logic             rst_n_i,
  input  ic_msg_pkg::msg_t in_msg_i,
  input  logic             in_val_i,
  output logic             in_rdy_o,
  output ic_msg_pkg::msg_t out_msg_o,
  output logic             out_val_o,
  input  logic             out_rdy_i
);

  localparam int N_SRC = 3;

  // router to crossbar
  ic_msg_pkg::data_t      xbar_in_data;
  logic [1:0]             xbar_in_val;
  logic [1:0]             xbar_in_rdy;
  ic_map_pkg::xbar_ctrl_t xbar_cfg;
  logic                   xbar_cfg_val;

  // router to arbiter
  ic_msg_pkg::data_t loop_data;
  logic              loop_val;
  logic              loop_rdy;

  // crossbar to arbiter
  ic_msg_pkg::data_t [1:0] xbar_out_data;
  logic [1:0]              xbar_out_val;
  logic [1:0]              xbar_out_rdy;

  // arbiter sources
  ic_msg_pkg::data_t [N_SRC-1:0] arb_data;
  logic [N_SRC-1:0]              arb_val;
  logic [N_SRC-1:0]              arb_rdy;

  // ==============================
  // input side
  // ==============================

  msg_router msg_router_i (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .in_msg_i   (in_msg_i),
    .in_val_i   (in_val_i),
    .in_rdy_o   (in_rdy_o),
    .xbar_data_o(xbar_in_data),
    .xbar_val_o (xbar_in_val),
    .xbar_rdy_i (xbar_in_rdy),
    .cfg_o      (xbar_cfg),
    .cfg_val_o  (xbar_cfg_val),
    .loop_data_o(loop_data),
    .loop_val_o (loop_val),
    .loop_rdy_i (loop_rdy)
  );

  // ==============================
  // crossbar
  // ==============================

  blocking_xbar blocking_xbar_i (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .in_data_i (xbar_in_data),
    .in_val_i  (xbar_in_val),
    .in_rdy_o  (xbar_in_rdy),
    .cfg_i     (xbar_cfg),
    .cfg_val_i (xbar_cfg_val),
    .out_data_o(xbar_out_data),
    .out_val_o (xbar_out_val),
    .out_rdy_i (xbar_out_rdy)
  );

  // ==============================
  // output side
  // ==============================

  // xbar out0, xbar out1, loopback as sources 0 to 2
  assign arb_data[ic_map_pkg::SRC_XBAR_OUT0] = xbar_out_data[0];
  assign arb_data[ic_map_pkg::SRC_XBAR_OUT1] = xbar_out_data[1];
  assign arb_data[ic_map_pkg::SRC_LOOPBACK]  = loop_data;
  assign arb_val[ic_map_pkg::SRC_XBAR_OUT0]  = xbar_out_val[0];
  assign arb_val[ic_map_pkg::SRC_XBAR_OUT1]  = xbar_out_val[1];
  assign arb_val[ic_map_pkg::SRC_LOOPBACK]   = loop_val;
  assign xbar_out_rdy[0] = arb_rdy[ic_map_pkg::SRC_XBAR_OUT0];
  assign xbar_out_rdy[1] = arb_rdy[ic_map_pkg::SRC_XBAR_OUT1];
  assign loop_rdy        = arb_rdy[ic_map_pkg::SRC_LOOPBACK];

  rr_arbiter #(
    .N_SRC(N_SRC)
  ) rr_arbiter_i (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .src_data_i(arb_data),
    .src_val_i (arb_val),
    .src_rdy_o (arb_rdy),
    .out_msg_o (out_msg_o),
    .out_val_o (out_val_o),
    .out_rdy_i (out_rdy_i)
  );

endmodule

// ==== verification/tb_msg_interconnect.sv ====
module tb_msg_interconnect;

  logic             clk;
  logic             rst_n_i;
  ic_msg_pkg::msg_t in_msg_i;
  logic             in_val_i;
  logic             in_rdy_o;
  ic_msg_pkg::msg_t out_msg_o;
  logic             out_val_o;
  logic             out_rdy_i = 1'b1;

  // 0 always ready, 1 random stalls, 2 held low
  int rdy_mode = 0;
  int n_sent   = 0;
  int cycles   = 0;
  int errors   = 0;
  int checks   = 0;
  int n_tests  = 0;

  // model route follows accepted config words, stim route follows sent ones
  ic_map_pkg::xbar_ctrl_t model_route = ic_map_pkg::XBAR_RESET_CTRL;
  ic_map_pkg::xbar_ctrl_t stim_route  = ic_map_pkg::XBAR_RESET_CTRL;

  // expected payloads per arbiter source
  ic_msg_pkg::data_t exp_q0[$];
  ic_msg_pkg::data_t exp_q1[$];
  ic_msg_pkg::data_t exp_q2[$];

  msg_interconnect msg_interconnect_i (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .in_msg_i (in_msg_i),
    .in_val_i (in_val_i),
    .in_rdy_o (in_rdy_o),
    .out_msg_o(out_msg_o),
    .out_val_o(out_val_o),
    .out_rdy_i(out_rdy_i)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ==============================
  // reference model
  // ==============================

  // source that should carry an accepted message, -1 when nothing comes out
  function automatic int expected_src(input ic_msg_pkg::msg_t msg,
                                      input ic_map_pkg::xbar_ctrl_t route);
    int src;
    src = -1;
    if (msg.addr == 4'd3) begin
      src = 2;
    end else if (msg.addr < 4'd2 && msg.addr[0] == route.in_sel) begin
      src = route.out_sel ? 1 : 0;
    end
    return src;
  endfunction

  function automatic int queue_size(input ic_map_pkg::src_id_t src);
    case (src)
      2'd0: return exp_q0.size();
      2'd1: return exp_q1.size();
      2'd2: return exp_q2.size();
      default: return 0;
    endcase
  endfunction

  task automatic push_expected(input int src, input ic_msg_pkg::data_t data);
    case (src)
      0: exp_q0.push_back(data);
      1: exp_q1.push_back(data);
      default: exp_q2.push_back(data);
    endcase
  endtask

  task automatic pop_expected(input ic_map_pkg::src_id_t src,
                              output ic_msg_pkg::data_t data);
    case (src)
      2'd0: data = exp_q0.pop_front();
      2'd1: data = exp_q1.pop_front();
      default: data = exp_q2.pop_front();
    endcase
  endtask

  // watch the input side and predict
  always @(posedge clk) begin
    int src;
    if (rst_n_i && in_val_i && in_rdy_o) begin
      src = expected_src(in_msg_i, model_route);
      if (in_msg_i.addr == 4'd2) begin
        model_route = ic_map_pkg::xbar_ctrl_t'(in_msg_i.data[1:0]);
      end else if (src >= 0) begin
        push_expected(src, in_msg_i.data);
      end
    end
  end

  // ==============================
  // checks and compare
  // ==============================

  task automatic check_src(input ic_map_pkg::src_id_t src, output bit ok);
    checks++;
    ok = (src <= ic_map_pkg::SRC_LOOPBACK) && (queue_size(src) > 0);
    if (!ok) begin
      errors++;
      $display("ERR %0t: output on source %0d with no message expected", $time, src);
    end
  endtask

  task automatic check_data(input ic_msg_pkg::data_t got, input ic_msg_pkg::data_t exp,
                            input ic_map_pkg::src_id_t src);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: source %0d payload %h, expected %h", $time, src, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  always @(posedge clk) begin
    ic_msg_pkg::data_t   exp_data;
    ic_map_pkg::src_id_t src;
    bit                  ok;
    if (rst_n_i && out_val_o && out_rdy_i) begin
      src = out_msg_o.addr[1:0];
      if (out_msg_o.addr[3:2] != 2'b00) begin
        errors++;
        $display("ERR %0t: source field %0d out of range", $time, out_msg_o.addr);
      end else begin
        check_src(src, ok);
        if (ok) begin
          pop_expected(src, exp_data);
          check_data(out_msg_o.data, exp_data, src);
        end
      end
    end
  end

  // ==============================
  // stimulus
  // ==============================

  always @(posedge clk) begin
    if (rdy_mode == 1) begin
      out_rdy_i <= ($urandom_range(2, 0) != 0);
    end else begin
      out_rdy_i <= (rdy_mode == 0);
    end
  end

  // called right after a rising edge, returns on the edge that takes the message
  task automatic send_msg(input ic_msg_pkg::addr_t dst, input ic_msg_pkg::data_t payload);
    in_msg_i <= '{addr: dst, data: payload};
    in_val_i <= 1'b1;
    n_sent++;
    do begin
      @(posedge clk);
    end while (!in_rdy_o);
  endtask

  // xbar data only to the selected input, the other one would block
  task automatic send_random(input int n);
    int                kind;
    ic_msg_pkg::data_t payload;
    for (int i = 0; i < n; i++) begin
      kind    = $urandom_range(7, 0);
      payload = ic_msg_pkg::data_t'($urandom);
      if (kind < 3) begin
        send_msg(ic_msg_pkg::addr_t'(stim_route.in_sel), payload);
      end else if (kind < 5) begin
        send_msg(4'd3, payload);
      end else if (kind == 5) begin
        send_msg(4'd2, payload);
        stim_route = ic_map_pkg::xbar_ctrl_t'(payload[1:0]);
      end else begin
        send_msg(ic_msg_pkg::addr_t'($urandom_range(15, 4)), payload);
      end
    end
  endtask

  task automatic end_test(input string name, input int err_start);
    in_val_i <= 1'b0;
    do begin
      @(posedge clk);
    end while (exp_q0.size() + exp_q1.size() + exp_q2.size() != 0 || out_val_o);
    // a few idle cycles to catch late duplicates
    repeat (4) @(posedge clk);
    n_tests++;
    if (errors == err_start) begin
      $display("test %0d %s: ok", n_tests, name);
    end else begin
      $display("test %0d %s: %0d errors", n_tests, name, errors - err_start);
    end
  endtask

  // ==============================
  // watchdog
  // ==============================

  always @(posedge clk) begin
    cycles++;
    if (cycles > 20 * n_sent + 200) begin
      $display("timeout after %0d cycles, outputs did not drain", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    int err_start;
    void'($urandom(52657));
    rst_n_i  = 1'b0;
    in_val_i = 1'b0;
    in_msg_i = '0;
    repeat (8) @(posedge clk);
    rst_n_i <= 1'b1;
    @(posedge clk);

    err_start = errors;
    // idle after reset, input open and output empty
    check_flag(in_rdy_o, 1'b1, "in_rdy_o");
    check_flag(out_val_o, 1'b0, "out_val_o");
    send_msg(4'd0, 16'h1234);
    send_msg(4'd3, 16'hbeef);
    end_test("reset route and loopback", err_start);

    // output held low so the config sits behind earlier data
    err_start = errors;
    rdy_mode  <= 2;
    send_msg(4'd0, 16'h0a0a);
    send_msg(4'd2, 16'h0003);
    stim_route = ic_map_pkg::xbar_ctrl_t'(2'b11);
    send_msg(4'd1, 16'h0b0b);
    rdy_mode <= 0;
    send_msg(4'd1, 16'h0c0c);
    end_test("config in1 to out1", err_start);

    err_start = errors;
    for (int a = 4; a < 16; a++) begin
      send_msg(ic_msg_pkg::addr_t'(a), ic_msg_pkg::data_t'($urandom));
    end
    send_msg(4'd1, 16'h5555);
    send_msg(4'd3, 16'h6666);
    end_test("unmapped addresses dropped", err_start);

    err_start = errors;
    send_random(60);
    end_test("mixed traffic", err_start);

    err_start = errors;
    rdy_mode  <= 1;
    send_random(150);
    end_test("random back-pressure", err_start);
    rdy_mode <= 0;

    $display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== msg_interconnect.f ====
src/ic_msg_pkg.sv
src/ic_map_pkg.sv
src/msg_router.sv
src/blocking_xbar.sv
src/rr_arbiter.sv
src/msg_interconnect.sv
verification/tb_msg_interconnect.sv

// ==== Makefile ====
# Verilator build and run of the message interconnect testbench

TOP := tb_msg_interconnect
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) \
		-f msg_interconnect.f --Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf obj_dir $(LOG)
